// File: hw/exec_pkg.sv
package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths and constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int xlen = 32;                 // Default datapath width

    typedef logic [4:0] reg_addr_t;

    localparam logic      rst_active = 1'b0;  // Reset level
    localparam reg_addr_t zero_reg   = 5'd0;  // Hard-wired zero register

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [2:0] {
        bcu_beq,
        bcu_bne,
        bcu_blt,
        bcu_bge,
        bcu_bltu,
        bcu_bgeu
    } bcu_op_t;

    typedef enum logic [1:0] {
        div_div,
        div_divu,
        div_rem,
        div_remu
    } div_op_t;

    // Which unit produces the written value
    typedef enum logic [2:0] {
        cls_alu,
        cls_lui,
        cls_jal,
        cls_jalr,
        cls_branch,
        cls_div
    } instr_class_t;

    typedef enum logic [1:0] {
        ds_idle,
        ds_run,
        ds_done
    } div_state_t;

endpackage

// File: hw/int_alu.sv
module int_alu import exec_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [XLEN-1:0] imm,
    input  logic            use_imm,
    output logic [XLEN-1:0] result
);

    localparam int sh_w = $clog2(XLEN);

    logic [XLEN-1:0] opb;
    logic [sh_w-1:0] shamt;

    always_comb begin
        opb   = use_imm ? imm : b;
        shamt = opb[sh_w-1:0];                // Only the low bits count

        case (op)
            alu_add: begin
                result = a + opb;
            end
            alu_sub: begin
                result = a - opb;
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_slt: begin
                result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(opb)};
            end
            alu_sltu: begin
                result = {{(XLEN-1){1'b0}}, a < opb};
            end
            alu_xor: begin
                result = a ^ opb;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            alu_or: begin
                result = a | opb;
            end
            alu_and: begin
                result = a & opb;
            end
            default: begin
                result = '0;                  // Unused encodings
            end
        endcase
    end

endmodule

// File: hw/branch_unit.sv
module branch_unit import exec_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  bcu_op_t         op,
    input  logic            is_branch,
    input  logic            is_jal,
    input  logic            is_jalr,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    output logic            jump,
    output logic [XLEN-1:0] target,
    output logic            misaligned
);

    logic cond;
    logic taken;

    always_comb begin
        case (op)
            bcu_beq:  cond = (a == b);
            bcu_bne:  cond = (a != b);
            bcu_blt:  cond = ($signed(a) < $signed(b));
            bcu_bge:  cond = ($signed(a) >= $signed(b));
            bcu_bltu: cond = (a < b);
            bcu_bgeu: cond = (a >= b);
            default:  cond = 1'b0;
        endcase

        taken = is_jal | is_jalr | (is_branch & cond);

        if (is_jalr) begin
            target = (a + imm) & {{(XLEN-1){1'b1}}, 1'b0};  // Bit 0 dropped
        end else begin
            target = pc + imm;
        end

        misaligned = taken & target[1];        // Word aligned fetch only
        jump       = taken & ~target[1];
    end

endmodule

// File: hw/serial_divider.sv
module serial_divider import exec_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            abort,
    input  logic            freeze,
    input  div_op_t         op,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    output logic            done,
    output logic [XLEN-1:0] result
);

    localparam int cnt_w = $clog2(XLEN);

    div_state_t       state;
    logic [cnt_w-1:0] count;
    logic [XLEN-1:0]  quo;                    // Dividend bits shift out, quotient bits in
    logic [XLEN-1:0]  rem;
    logic [XLEN-1:0]  dvs;
    logic             neg_q;
    logic             neg_r;
    logic             want_rem;
    logic             is_signed;
    logic             a_neg;
    logic             b_neg;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;

    always_comb begin
        is_signed = (op == div_div) || (op == div_rem);
        a_neg     = is_signed & dividend[XLEN-1];
        b_neg     = is_signed & divisor[XLEN-1];
        shifted   = {rem, quo[XLEN-1]};
        diff      = shifted - {1'b0, dvs};
    end

    assign done = (state == ds_done);

    always_comb begin
        if (want_rem) begin
            result = neg_r ? -rem : rem;
        end else begin
            result = neg_q ? -quo : quo;
        end
    end

    always_ff @(posedge clk) begin
        if (rst == rst_active) begin
            state <= ds_idle;
        end else if (abort) begin
            state <= ds_idle;
        end else if (!freeze) begin
            case (state)
                ds_idle: begin
                    if (start) begin
                        state <= ds_run;
                    end
                end
                ds_run: begin
                    if (count == cnt_w'(XLEN - 1)) begin
                        state <= ds_done;
                    end
                end
                default: begin
                    state <= ds_idle;         // Result taken
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Restoring datapath, one quotient bit per cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!freeze) begin
            if (state == ds_idle && start) begin
                quo      <= a_neg ? -dividend : dividend;
                dvs      <= b_neg ? -divisor : divisor;
                rem      <= '0;
                count    <= '0;
                neg_q    <= (a_neg ^ b_neg) & (divisor != '0);  // Zero divisor keeps all ones
                neg_r    <= a_neg;
                want_rem <= (op == div_rem) || (op == div_remu);
            end else if (state == ds_run) begin
                count <= count + 1'b1;
                if (!diff[XLEN]) begin
                    rem <= diff[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b1};
                end else begin
                    rem <= shifted[XLEN-1:0];
                    quo <= {quo[XLEN-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: hw/reg_file.sv
module reg_file import exec_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic            clk,
    input  logic            rst,
    input  reg_addr_t       raddr1,
    input  reg_addr_t       raddr2,
    input  logic            wen,
    input  reg_addr_t       waddr,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [1:31];

    // Write-through read, forwards the stage output register
    function automatic logic [XLEN-1:0] read_port(input reg_addr_t addr);
        if (addr == zero_reg) begin
            return '0;
        end else if (wen && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

    always_ff @(posedge clk) begin
        if (rst == rst_active) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != zero_reg) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: hw/execute_stage.sv
module execute_stage import exec_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  instr_class_t    in_class,
    input  alu_op_t         in_alu_op,
    input  bcu_op_t         in_bcu_op,
    input  div_op_t         in_div_op,
    input  reg_addr_t       in_rd,
    input  logic            in_use_imm,
    input  logic [XLEN-1:0] in_imm,
    input  logic [XLEN-1:0] in_pc,
    input  logic [XLEN-1:0] rdata1,
    input  logic [XLEN-1:0] rdata2,
    input  logic            hold,
    input  logic            flush,
    input  logic [XLEN-1:0] alu_result,
    input  logic            bcu_jump,
    input  logic [XLEN-1:0] bcu_target,
    input  logic            bcu_misaligned,
    input  logic            div_done,
    input  logic [XLEN-1:0] div_result,
    output logic            in_ready,
    output logic [XLEN-1:0] src1,
    output logic [XLEN-1:0] src2,
    output alu_op_t         alu_op,
    output logic            alu_use_imm,
    output bcu_op_t         bcu_op,
    output logic            bcu_branch,
    output logic            bcu_jal,
    output logic            bcu_jalr,
    output div_op_t         div_op,
    output logic            div_start,
    output logic            div_abort,
    output logic            div_freeze,
    output logic            out_valid,
    output reg_addr_t       out_rd,
    output logic            out_wen,
    output logic [XLEN-1:0] out_wdata,
    output logic            out_jump,
    output logic [XLEN-1:0] out_target,
    output logic            out_exception
);

    logic            up_q;                    // First cycle after reset seen
    logic            busy;                    // Divide in flight
    reg_addr_t       pend_rd;
    logic            wen_q;
    logic            accept;
    logic            is_div;
    logic            nxt_valid;
    logic            nxt_wen;
    logic            nxt_jump;
    logic            nxt_exc;
    reg_addr_t       nxt_rd;
    logic [XLEN-1:0] nxt_wdata;
    logic [XLEN-1:0] exec_data;

    assign in_ready = up_q & ~busy & ~hold;
    assign accept   = in_valid & in_ready;
    assign is_div   = (in_class == cls_div);

    // Unit inputs
    assign src1        = rdata1;
    assign src2        = rdata2;
    assign alu_op      = in_alu_op;
    assign alu_use_imm = in_use_imm;
    assign bcu_op      = in_bcu_op;
    assign bcu_branch  = (in_class == cls_branch);
    assign bcu_jal     = (in_class == cls_jal);
    assign bcu_jalr    = (in_class == cls_jalr);
    assign div_op      = in_div_op;
    assign div_start   = accept & is_div;
    assign div_abort   = flush;
    assign div_freeze  = hold;

    assign out_wen = wen_q & ~hold;           // One write per result

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (in_class)
            cls_lui:           exec_data = in_imm;
            cls_jal, cls_jalr: exec_data = in_pc + XLEN'(4);  // Link value
            default:           exec_data = alu_result;
        endcase

        nxt_valid = 1'b0;
        nxt_wen   = 1'b0;
        nxt_jump  = 1'b0;
        nxt_exc   = 1'b0;
        nxt_rd    = in_rd;
        nxt_wdata = exec_data;

        if (busy) begin
            nxt_rd    = pend_rd;
            nxt_wdata = div_result;
            nxt_valid = div_done;
            nxt_wen   = div_done & (pend_rd != zero_reg);
        end else if (accept && !is_div) begin
            nxt_valid = 1'b1;
            nxt_wen   = (in_rd != zero_reg) && (in_class != cls_branch) && !bcu_misaligned;
            nxt_jump  = bcu_jump;
            nxt_exc   = bcu_misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (rst == rst_active) begin
            up_q          <= 1'b0;
            busy          <= 1'b0;
            out_valid     <= 1'b0;
            wen_q         <= 1'b0;
            out_jump      <= 1'b0;
            out_exception <= 1'b0;
        end else begin
            up_q <= 1'b1;
            if (flush) begin
                busy          <= 1'b0;
                out_valid     <= 1'b0;
                wen_q         <= 1'b0;
                out_jump      <= 1'b0;
                out_exception <= 1'b0;
            end else if (!hold) begin
                out_valid     <= nxt_valid;
                wen_q         <= nxt_wen;
                out_jump      <= nxt_jump;
                out_exception <= nxt_exc;
                if (busy && div_done) begin
                    busy <= 1'b0;
                end else if (div_start) begin
                    busy <= 1'b1;
                end
            end
        end
    end

    // Payload, qualified by out_valid
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_rd     <= nxt_rd;
            out_wdata  <= nxt_wdata;
            out_target <= bcu_target;
            if (div_start) begin
                pend_rd <= in_rd;
            end
        end
    end

endmodule

// File: hw/exec_top.sv
module exec_top import exec_pkg::*; #(
    parameter int XLEN = xlen
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            hold,
    input  logic            flush,
    input  logic            in_valid,
    output logic            in_ready,
    input  instr_class_t    in_class,
    input  alu_op_t         in_alu_op,
    input  bcu_op_t         in_bcu_op,
    input  div_op_t         in_div_op,
    input  reg_addr_t       in_rs1,
    input  reg_addr_t       in_rs2,
    input  reg_addr_t       in_rd,
    input  logic            in_use_imm,
    input  logic [XLEN-1:0] in_imm,
    input  logic [XLEN-1:0] in_pc,
    output logic            out_valid,
    output reg_addr_t       out_rd,
    output logic            out_wen,
    output logic [XLEN-1:0] out_wdata,
    output logic            out_jump,
    output logic [XLEN-1:0] out_target,
    output logic            out_exception
);

    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    alu_op_t         alu_op;
    logic            alu_use_imm;
    logic [XLEN-1:0] alu_result;
    bcu_op_t         bcu_op;
    logic            bcu_branch;
    logic            bcu_jal;
    logic            bcu_jalr;
    logic            bcu_jump;
    logic [XLEN-1:0] bcu_target;
    logic            bcu_misaligned;
    div_op_t         div_op;
    logic            div_start;
    logic            div_abort;
    logic            div_freeze;
    logic            div_done;
    logic [XLEN-1:0] div_result;

    reg_file #(.XLEN(XLEN)) i_reg_file (
        .clk, .rst,
        .raddr1 (in_rs1),
        .raddr2 (in_rs2),
        .wen    (out_wen),
        .waddr  (out_rd),
        .wdata  (out_wdata),
        .rdata1, .rdata2
    );

    execute_stage #(.XLEN(XLEN)) i_execute_stage (
        .clk, .rst, .in_valid, .in_class, .in_alu_op, .in_bcu_op, .in_div_op,
        .in_rd, .in_use_imm, .in_imm, .in_pc, .rdata1, .rdata2, .hold, .flush,
        .alu_result, .bcu_jump, .bcu_target, .bcu_misaligned, .div_done, .div_result,
        .in_ready, .src1, .src2, .alu_op, .alu_use_imm, .bcu_op, .bcu_branch,
        .bcu_jal, .bcu_jalr, .div_op, .div_start, .div_abort, .div_freeze,
        .out_valid, .out_rd, .out_wen, .out_wdata, .out_jump, .out_target,
        .out_exception
    );

    int_alu #(.XLEN(XLEN)) i_int_alu (
        .op      (alu_op),
        .a       (src1),
        .b       (src2),
        .imm     (in_imm),
        .use_imm (alu_use_imm),
        .result  (alu_result)
    );

    branch_unit #(.XLEN(XLEN)) i_branch_unit (
        .op         (bcu_op),
        .is_branch  (bcu_branch),
        .is_jal     (bcu_jal),
        .is_jalr    (bcu_jalr),
        .a          (src1),
        .b          (src2),
        .pc         (in_pc),
        .imm        (in_imm),
        .jump       (bcu_jump),
        .target     (bcu_target),
        .misaligned (bcu_misaligned)
    );

    serial_divider #(.XLEN(XLEN)) i_serial_divider (
        .clk, .rst,
        .start    (div_start),
        .abort    (div_abort),
        .freeze   (div_freeze),
        .op       (div_op),
        .dividend (src1),
        .divisor  (src2),
        .done     (div_done),
        .result   (div_result)
    );

endmodule

// File: bench/exec_tb.sv
module exec_tb import exec_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int num_instr    = 600;
    localparam int num_directed = 17;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = num_instr * (xlen + 4) + reset_cycles;
    localparam int sh_w         = $clog2(xlen);

    typedef struct packed {
        reg_addr_t       rd;
        logic            wen;
        logic [xlen-1:0] data;
        logic            jump;
        logic [xlen-1:0] target;
        logic            exc;
        logic            is_div;
    } result_t;

    logic            clk = 1'b0;
    logic            rst;
    logic            hold;
    logic            flush;
    logic            in_valid;
    logic            in_ready;
    instr_class_t    in_class;
    alu_op_t         in_alu_op;
    bcu_op_t         in_bcu_op;
    div_op_t         in_div_op;
    reg_addr_t       in_rs1;
    reg_addr_t       in_rs2;
    reg_addr_t       in_rd;
    logic            in_use_imm;
    logic [xlen-1:0] in_imm;
    logic [xlen-1:0] in_pc;
    logic            out_valid;
    reg_addr_t       out_rd;
    logic            out_wen;
    logic [xlen-1:0] out_wdata;
    logic            out_jump;
    logic [xlen-1:0] out_target;
    logic            out_exception;

    logic [xlen-1:0] shadow [0:31];           // Architectural state seen by the model
    result_t         exp_q [$];
    logic            div_pending;
    reg_addr_t       last_rd;
    int              mismatch_count;
    int              other_count;
    int              cycle_count;
    int              issued;
    logic            have_instr;

    exec_top #(.XLEN(xlen)) i_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            other_count++;
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            end_run();
        end
    end

    task automatic end_run();
        $display("Closing: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] expected);
        if (got !== expected) begin
            mismatch_count++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [xlen-1:0] alu_model(alu_op_t op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b);
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << b[sh_w-1:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 1 : 0;
            alu_sltu: return (a < b) ? 1 : 0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> b[sh_w-1:0];
            alu_sra:  return $signed(a) >>> b[sh_w-1:0];
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic [xlen-1:0] div_model(div_op_t op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b);
        logic                   overflow;
        logic signed [xlen-1:0] sq;
        logic signed [xlen-1:0] sr;
        overflow = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);
        sq       = '0;
        sr       = '0;
        if (b != 0 && !overflow) begin
            sq = $signed(a) / $signed(b);
            sr = $signed(a) % $signed(b);
        end
        case (op)
            div_divu: return (b == 0) ? '1 : a / b;
            div_remu: return (b == 0) ? a : a % b;
            div_div: begin
                if (b == 0) begin
                    return '1;
                end else if (overflow) begin
                    return a;
                end
                return sq;
            end
            default: begin
                if (b == 0) begin
                    return a;
                end else if (overflow) begin
                    return '0;
                end
                return sr;
            end
        endcase
    endfunction

    function automatic logic branch_taken(bcu_op_t op, logic [xlen-1:0] a,
                                          logic [xlen-1:0] b);
        case (op)
            bcu_beq:  return a == b;
            bcu_bne:  return a != b;
            bcu_blt:  return $signed(a) < $signed(b);
            bcu_bge:  return $signed(a) >= $signed(b);
            bcu_bltu: return a < b;
            default:  return a >= b;
        endcase
    endfunction

    // Expected outcome of the instruction on the in_ ports, pushed at accept
    task automatic predict_result();
        result_t         e;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic            taken;
        a        = shadow[in_rs1];
        b        = shadow[in_rs2];
        e        = '0;
        e.rd     = in_rd;
        e.is_div = (in_class == cls_div);
        e.target = in_pc + in_imm;
        taken    = 1'b0;
        case (in_class)
            cls_alu:    e.data = alu_model(in_alu_op, a, in_use_imm ? in_imm : b);
            cls_lui:    e.data = in_imm;
            cls_jal: begin
                e.data = in_pc + 4;
                taken  = 1'b1;
            end
            cls_jalr: begin
                e.data   = in_pc + 4;
                taken    = 1'b1;
                e.target = (a + in_imm) & ~{{(xlen-1){1'b0}}, 1'b1};
            end
            cls_branch: taken = branch_taken(in_bcu_op, a, b);
            default:    e.data = div_model(in_div_op, a, b);
        endcase
        e.exc  = taken & e.target[1];         // Fetch is word aligned
        e.jump = taken & ~e.target[1];
        e.wen  = (in_rd != 0) && (in_class != cls_branch) && !e.exc;
        exp_q.push_back(e);
        if (e.is_div) begin
            div_pending = 1'b1;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic set_instr(input instr_class_t c, input alu_op_t ao, input bcu_op_t bo,
                             input div_op_t dop, input reg_addr_t s1, input reg_addr_t s2,
                             input reg_addr_t d, input logic ui, input logic [xlen-1:0] im,
                             input logic [xlen-1:0] p);
        in_class   = c;
        in_alu_op  = ao;
        in_bcu_op  = bo;
        in_div_op  = dop;
        in_rs1     = s1;
        in_rs2     = s2;
        in_rd      = d;
        in_use_imm = ui;
        in_imm     = im;
        in_pc      = p;
        last_rd    = d;
    endtask

    task automatic load_directed(input int k);
        case (k)
            0:  set_instr(cls_lui, alu_add, bcu_beq, div_div, 0, 0, 1, 1, 32'h8000_0000, 0);
            1:  set_instr(cls_lui, alu_add, bcu_beq, div_div, 0, 0, 2, 1, 32'hffff_ffff, 0);
            2:  set_instr(cls_div, alu_add, bcu_beq, div_div, 1, 2, 3, 0, 0, 0);  // Overflow
            3:  set_instr(cls_div, alu_add, bcu_beq, div_rem, 1, 2, 4, 0, 0, 0);
            4:  set_instr(cls_div, alu_add, bcu_beq, div_divu, 1, 0, 5, 0, 0, 0); // By zero
            5:  set_instr(cls_div, alu_add, bcu_beq, div_rem, 2, 0, 6, 0, 0, 0);
            6:  set_instr(cls_alu, alu_add, bcu_beq, div_div, 1, 0, 0, 1, 5, 0);
            7:  set_instr(cls_alu, alu_or, bcu_beq, div_div, 0, 2, 7, 0, 0, 0);
            8:  set_instr(cls_alu, alu_sra, bcu_beq, div_div, 1, 0, 8, 1, 4, 0);
            9:  set_instr(cls_alu, alu_add, bcu_beq, div_div, 9, 0, 9, 1, 7, 0);
            10: set_instr(cls_alu, alu_add, bcu_beq, div_div, 9, 0, 9, 1, 7, 0);
            11: set_instr(cls_alu, alu_sub, bcu_beq, div_div, 9, 1, 10, 0, 0, 0);
            12: set_instr(cls_jalr, alu_add, bcu_beq, div_div, 1, 0, 11, 1, 2, 32'h40);
            13: set_instr(cls_jal, alu_add, bcu_beq, div_div, 0, 0, 12, 1, 32'h20, 32'h100);
            14: set_instr(cls_branch, alu_add, bcu_bge, div_div, 3, 1, 0, 1, 32'h40, 32'h200);
            15: set_instr(cls_branch, alu_add, bcu_bltu, div_div, 2, 1, 0, 1, 8, 32'h300);
            default: set_instr(cls_div, alu_add, bcu_beq, div_div, 2, 8, 13, 0, 0, 0);
        endcase
    endtask

    // Biased toward the corner values of the divider and comparators
    function automatic logic [xlen-1:0] random_data();
        case ($urandom_range(0, 7))
            0:       return '0;
            1:       return '1;
            2:       return {1'b1, {(xlen-1){1'b0}}};
            3:       return 1;
            4:       return $urandom_range(0, 63);
            default: return $urandom;
        endcase
    endfunction

    task automatic load_random();
        int              r;
        instr_class_t    c;
        reg_addr_t       s1;
        r = $urandom_range(0, 99);
        c = (r < 40) ? cls_alu : (r < 55) ? cls_lui : (r < 63) ? cls_jal :
            (r < 73) ? cls_jalr : (r < 85) ? cls_branch : cls_div;
        s1 = $urandom_range(0, 1) ? last_rd : reg_addr_t'($urandom_range(0, 31));
        set_instr(c, alu_op_t'($urandom_range(0, 9)), bcu_op_t'($urandom_range(0, 5)),
                  div_op_t'($urandom_range(0, 3)), s1, reg_addr_t'($urandom_range(0, 31)),
                  reg_addr_t'($urandom_range(0, 31)), $urandom_range(0, 1), random_data(),
                  $urandom & 32'hffff_fffc);
    endtask

    // Called just after the falling edge, decides what the next rising edge does
    task automatic observe_outputs();
        result_t e;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("Result for rd %0d appeared with no instruction outstanding", out_rd);
            end else begin
                e = exp_q[0];
                check_value("out_rd", out_rd, e.rd);
                check_value("out_wen", out_wen, e.wen & ~hold);
                check_value("out_jump", out_jump, e.jump);
                check_value("out_exception", out_exception, e.exc);
                if (e.wen) begin
                    check_value("out_wdata", out_wdata, e.data);
                end
                if (e.jump || e.exc) begin
                    check_value("out_target", out_target, e.target);
                end
                if (!hold) begin                // Taken downstream at this edge
                    void'(exp_q.pop_front());
                    if (e.wen) begin
                        shadow[e.rd] = e.data;
                    end
                    if (e.is_div) begin
                        div_pending = 1'b0;
                    end
                end
            end
        end else begin
            check_value("out_wen", out_wen, 1'b0);
        end
        if (div_pending && !out_valid && in_ready) begin
            other_count++;
            $display("in_ready went high while a divide was still running");
        end
        if (in_valid && in_ready && !flush) begin
            predict_result();
        end
        if (flush) begin
            exp_q.delete();                   // Nothing in flight survives a flush
            div_pending = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(32'h2db7));
        rst         = 1'b0;
        hold        = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        set_instr(cls_alu, alu_add, bcu_beq, div_div, 0, 0, 0, 0, 0, 0);
        div_pending = 1'b0;
        have_instr  = 1'b0;
        issued      = 0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end

        repeat (reset_cycles) @(negedge clk);
        check_value("out_valid", out_valid, 1'b0);
        check_value("out_wen", out_wen, 1'b0);
        check_value("out_jump", out_jump, 1'b0);
        check_value("out_exception", out_exception, 1'b0);
        check_value("in_ready", in_ready, 1'b0);
        rst = 1'b1;
        @(negedge clk);
        #1;
        check_value("in_ready", in_ready, 1'b1);

        while (issued < num_instr) begin
            @(negedge clk);
            if (!have_instr) begin
                if (issued < num_directed) begin
                    load_directed(issued);
                end else begin
                    load_random();
                end
                have_instr = 1'b1;
            end
            in_valid = ($urandom_range(0, 9) != 0);
            hold     = ($urandom_range(0, 6) == 0);
            flush    = (issued >= num_directed) && ($urandom_range(0, 29) == 0);
            #1;
            observe_outputs();
            if (in_valid && in_ready) begin
                have_instr = 1'b0;              // Accepted or dropped by the flush
                issued++;
            end
        end

        // Drain, then a few idle cycles to catch stray results
        while (exp_q.size() != 0) begin
            @(negedge clk);
            in_valid = 1'b0;
            flush    = 1'b0;
            hold     = ($urandom_range(0, 6) == 0);
            #1;
            observe_outputs();
        end
        hold = 1'b0;
        repeat (4) begin
            @(negedge clk);
            #1;
            observe_outputs();
        end
        if (exp_q.size() != 0) begin
            other_count++;
            $display("%0d expected results never appeared", exp_q.size());
        end
        end_run();
    end

endmodule

// File: all.f
hw/exec_pkg.sv
hw/int_alu.sv
hw/branch_unit.sv
hw/serial_divider.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/exec_top.sv
bench/exec_tb.sv

// File: Bender.yml
package:
  name: exec_stage

sources:
  - hw/exec_pkg.sv
  - hw/int_alu.sv
  - hw/branch_unit.sv
  - hw/serial_divider.sv
  - hw/reg_file.sv
  - hw/execute_stage.sv
  - hw/exec_top.sv
  - target: simulation
    files:
      - bench/exec_tb.sv
